/* bench/tb_vmul_model.svh */
//////////////////////////////
// multiply unit reference model
// element arithmetic, operand LFSR and compare tasks
//////////////////////////////

`ifndef tb_vmul_model_svh
`define tb_vmul_model_svh

localparam int op_vmul    = 0;
localparam int op_vmulh   = 1;
localparam int op_vmulhu  = 2;
localparam int op_vmulhsu = 3;
localparam int op_vsmul   = 4;

int          err_count   = 0;
int          check_count = 0;
logic [31:0] lfsr_state  = 32'd38;

// galois lfsr, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsr_bit();
  logic out;
  out        = lfsr_state[0];
  lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
  return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    r[i] = lfsr_bit();
  end
  return r;
endfunction

function automatic vreg_t rand_vreg();
  vreg_t v;
  for (int k = 0; k < vlenb / 4; k++) begin
    v.w[k] = rand_bits(32);
  end
  return v;
endfunction

function automatic logic [31:0] get_elem(input vreg_t v, input int w, input int i);
  case (w)
    8:       return {24'd0, v.b[i]};
    16:      return {16'd0, v.h[i]};
    default: return v.w[i];
  endcase
endfunction

function automatic vreg_t set_elem(input vreg_t v, input int w, input int i,
                                   input logic [31:0] x);
  case (w)
    8:       v.b[i] = x[7:0];
    16:      v.h[i] = x[15:0];
    default: v.w[i] = x;
  endcase
  return v;
endfunction

function automatic vreg_t splat_scalar(input logic [31:0] x, input int w);
  vreg_t v;
  v = '0;
  for (int i = 0; i < vlen / w; i++) begin
    v = set_elem(v, w, i, x);   // low w bits in every element
  end
  return v;
endfunction

// one element, returns {sat, value}
function automatic logic [32:0] elem_result(input int op, input logic [1:0] vxrm,
                                            input int w, input logic [31:0] a,
                                            input logic [31:0] b);
  logic [31:0]        mask;
  logic [31:0]        minv;
  logic signed [65:0] sa;
  logic signed [65:0] sb;
  logic signed [65:0] p;
  logic signed [65:0] q;
  logic               lsb;
  logic               half;
  logic               below;
  logic               inc;
  mask = 32'hffff_ffff >> (32 - w);
  minv = 32'd1 << (w - 1);
  sa   = $signed({34'd0, a & mask});
  sb   = $signed({34'd0, b & mask});
  if (op != op_vmulhu && a[w-1]) sa = sa - (66'sd1 <<< w);   // a signed
  if ((op == op_vmul || op == op_vmulh || op == op_vsmul) && b[w-1]) begin
    sb = sb - (66'sd1 <<< w);
  end
  p = sa * sb;
  if (op == op_vmul) return {1'b0, 32'(p) & mask};
  if (op != op_vsmul) return {1'b0, 32'(p >>> w) & mask};
  if ((a & mask) == minv && (b & mask) == minv) return {1'b1, minv - 32'd1};
  lsb   = p[w-1];                                     // kept lsb
  half  = p[w-2];                                     // top discarded bit
  below = (p & ((66'sd1 <<< (w - 2)) - 66'sd1)) != 0;
  case (vxrm)
    vxrm_rnu: inc = half;
    vxrm_rne: inc = half & (below | lsb);
    vxrm_rdn: inc = 1'b0;
    default:  inc = ~lsb & (half | below);
  endcase
  q = (p >>> (w - 1)) + {65'd0, inc};
  return {1'b0, 32'(q) & mask};
endfunction

function automatic void form_expect(input int op, input logic [1:0] vxrm,
                                    input logic [2:0] eew, input logic vx,
                                    input vreg_t vs2, input vreg_t vs1,
                                    input logic [31:0] rs1, input logic [2:0] valids,
                                    output vreg_t d, output vmask_t s);
  vreg_t       a;
  vreg_t       b;
  int          w;
  logic [32:0] r;
  w = 8 << eew;
  a = valids[2] ? vs2 : '0;                   // valids is {vs2, vs1, rs1}
  if (vx) b = splat_scalar(valids[0] ? rs1 : 32'd0, w);
  else b = valids[1] ? vs1 : '0;
  d = '0;
  s = '0;
  for (int i = 0; i < vlen / w; i++) begin
    r = elem_result(op, vxrm, w, get_elem(a, w, i), get_elem(b, w, i));
    d = set_elem(d, w, i, r[31:0]);
    s[(i + 1) * (w / 8) - 1] = r[32];          // top byte lane of element
  end
endfunction

//////////////////////////////
// compare tasks
task automatic check_data(input vreg_t got, input vreg_t exp, input string what);
  check_count++;
  if (got !== exp) begin
    $display("[FAIL] %0t ns %s: rslt_data %h, expected %h", $time, what, got, exp);
    err_count++;
  end
endtask

task automatic check_vxsat(input vmask_t got, input vmask_t exp, input string what);
  check_count++;
  if (got !== exp) begin
    $display("[FAIL] %0t ns %s: rslt_vxsat %h, expected %h", $time, what, got, exp);
    err_count++;
  end
endtask

task automatic check_entry(input logic [rob_idx_width-1:0] got,
                           input logic [rob_idx_width-1:0] exp, input string what);
  check_count++;
  if (got !== exp) begin
    $display("[FAIL] %0t ns %s: rslt_rob_entry %0d, expected %0d", $time, what, got, exp);
    err_count++;
  end
endtask

`endif

/* bench/tb_vmul_unit.sv */
//////////////////////////////
// multiply unit testbench
// directed tests of every multiply form against the model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_vmul_unit
  import vmul_cfg_pkg::*, vmul_op_pkg::*;
();

  localparam int n_tests         = 6;
  localparam int cycles_per_test = 150;   // longest test is about 75
  localparam int margin          = 100;

  logic                     clk = 1'b0;
  logic                     reset;
  logic                     uop_valid;
  logic [2:0]               uop_funct3;
  logic [5:0]               uop_funct6;
  logic [1:0]               uop_vxrm;
  logic [2:0]               uop_eew;
  logic [rob_idx_width-1:0] uop_rob_entry;
  vreg_t                    vs1_data;
  logic                     vs1_valid;
  vreg_t                    vs2_data;
  logic                     vs2_valid;
  logic [xlen-1:0]          rs1_data;
  logic                     rs1_valid;
  logic                     rslt_valid;
  logic [rob_idx_width-1:0] rslt_rob_entry;
  vreg_t                    rslt_data;
  vmask_t                   rslt_vxsat;
  int                       tests_run = 0;

  `include "tb_vmul_model.svh"

  always #10 clk = ~clk;   // 20 ns period

  vmul_unit i_vmul_unit (
    .clk            (clk),
    .reset          (reset),
    .uop_valid      (uop_valid),
    .uop_funct3     (uop_funct3),
    .uop_funct6     (uop_funct6),
    .uop_vxrm       (uop_vxrm),
    .uop_eew        (uop_eew),
    .uop_rob_entry  (uop_rob_entry),
    .vs1_data       (vs1_data),
    .vs1_valid      (vs1_valid),
    .vs2_data       (vs2_data),
    .vs2_valid      (vs2_valid),
    .rs1_data       (rs1_data),
    .rs1_valid      (rs1_valid),
    .rslt_valid     (rslt_valid),
    .rslt_rob_entry (rslt_rob_entry),
    .rslt_data      (rslt_data),
    .rslt_vxsat     (rslt_vxsat)
  );

  //////////////////////////////
  // uop drive and result wait
  task automatic drive_uop(input int op, input logic [1:0] vxrm, input logic [2:0] eew,
                           input logic vx, input vreg_t vs2, input vreg_t vs1,
                           input logic [xlen-1:0] rs1, input logic [2:0] valids,
                           input logic [rob_idx_width-1:0] entry);
    uop_valid = 1'b1;
    if (op == op_vsmul) uop_funct3 = vx ? opivx : opivv;
    else uop_funct3 = vx ? opmvx : opmvv;
    case (op)
      op_vmulh:   uop_funct6 = f6_vmulh;
      op_vmulhu:  uop_funct6 = f6_vmulhu;
      op_vmulhsu: uop_funct6 = f6_vmulhsu;
      op_vsmul:   uop_funct6 = f6_vsmul;
      default:    uop_funct6 = f6_vmul;
    endcase
    uop_vxrm      = vxrm;
    uop_eew       = eew;
    uop_rob_entry = entry;
    vs2_data      = vs2;
    vs2_valid     = valids[2];
    vs1_data      = vs1;
    vs1_valid     = valids[1];
    rs1_data      = rs1;
    rs1_valid     = valids[0];
  endtask

  task automatic run_uop(input int op, input logic [1:0] vxrm, input logic [2:0] eew,
                         input logic vx, input vreg_t vs2, input vreg_t vs1,
                         input logic [xlen-1:0] rs1, input logic [2:0] valids,
                         input string what);
    vreg_t                    exp_d;
    vmask_t                   exp_s;
    logic [rob_idx_width-1:0] ent;
    int                       waited;
    ent = rob_idx_width'(rand_bits(rob_idx_width));
    form_expect(op, vxrm, eew, vx, vs2, vs1, rs1, valids, exp_d, exp_s);
    @(negedge clk);
    drive_uop(op, vxrm, eew, vx, vs2, vs1, rs1, valids, ent);
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!rslt_valid && waited < 4);   // give up after 4 cycles
    uop_valid = 1'b0;
    if (!rslt_valid) begin
      $display("%s: no result came back within %0d cycles", what, waited);
      err_count++;
    end else begin
      if (waited != 1) begin
        $display("%s: result came after %0d cycles instead of 1", what, waited);
        err_count++;
      end
      check_entry(rslt_rob_entry, ent, what);
      check_data(rslt_data, exp_d, what);
      check_vxsat(rslt_vxsat, exp_s, what);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) $display("test %-18s passed", name);
    else $display("test %-18s failed with %0d errors", name, err_count - errs_before);
  endtask

  // operands that put the discarded bits at half an lsb and around it
  function automatic vreg_t boundary_operand(input int w, input logic second);
    vreg_t       v;
    logic [31:0] h;
    logic [31:0] x;
    v = '0;
    h = 32'd1 << (w / 2 - 1);
    for (int i = 0; i < vlen / w; i++) begin
      if (second) begin
        x = (i % 8 >= 4) ? -h : h;
      end else begin
        case (i % 4)
          0:       x = h;          // exact half, kept lsb 0
          1:       x = 3 * h;      // exact half, kept lsb 1
          2:       x = h + 1;      // just above half
          default: x = -h;
        endcase
      end
      v = set_elem(v, w, i, x);
    end
    return v;
  endfunction

  //////////////////////////////
  // directed tests
  task automatic vmul_low_half();
    int e0;
    e0 = err_count;
    for (int e = 0; e < 3; e++) begin
      for (int k = 0; k < 4; k++) begin
        run_uop(op_vmul, vxrm_rnu, 3'(e), 1'b0, rand_vreg(), rand_vreg(), 32'd0, 3'b110,
                "vmul.vv");
      end
    end
    report_test("vmul low half", e0);
  endtask

  task automatic high_half_forms();
    int e0;
    e0 = err_count;
    for (int op = op_vmulh; op <= op_vmulhsu; op++) begin
      for (int e = 0; e < 3; e++) begin
        for (int k = 0; k < 2; k++) begin
          run_uop(op, vxrm_rnu, 3'(e), 1'b0, rand_vreg(), rand_vreg(), 32'd0, 3'b110,
                  "vmulh forms");
        end
      end
    end
    report_test("high half forms", e0);
  endtask

  task automatic scalar_and_invalid();
    int e0;
    e0 = err_count;
    for (int e = 0; e < 3; e++) begin
      run_uop(op_vmul, vxrm_rnu, 3'(e), 1'b1, rand_vreg(), '0, rand_bits(32), 3'b101,
              "vmul.vx");
      run_uop(op_vmulhsu, vxrm_rnu, 3'(e), 1'b1, rand_vreg(), '0, rand_bits(32), 3'b101,
              "vmulhsu.vx");
      run_uop(op_vsmul, vxrm_rne, 3'(e), 1'b1, rand_vreg(), '0, rand_bits(32), 3'b101,
              "vsmul.vx");
    end
    // each source invalid in turn, result must read zero
    run_uop(op_vmul, vxrm_rnu, eew16, 1'b0, rand_vreg(), rand_vreg(), 32'd0, 3'b010,
            "vs2 invalid");
    run_uop(op_vmul, vxrm_rnu, eew32, 1'b0, rand_vreg(), rand_vreg(), 32'd0, 3'b100,
            "vs1 invalid");
    run_uop(op_vmulh, vxrm_rnu, eew8, 1'b1, rand_vreg(), '0, rand_bits(32), 3'b100,
            "rs1 invalid");
    report_test("scalar and invalid", e0);
  endtask

  task automatic vsmul_rounding();
    int e0;
    int w;
    e0 = err_count;
    for (int m = 0; m < 4; m++) begin
      for (int e = 0; e < 3; e++) begin
        w = 8 << e;
        for (int k = 0; k < 2; k++) begin
          run_uop(op_vsmul, 2'(m), 3'(e), 1'b0, rand_vreg(), rand_vreg(), 32'd0, 3'b110,
                  "vsmul random");
        end
        run_uop(op_vsmul, 2'(m), 3'(e), 1'b0, boundary_operand(w, 1'b0),
                boundary_operand(w, 1'b1), 32'd0, 3'b110, "vsmul boundary");
      end
    end
    report_test("vsmul rounding", e0);
  endtask

  task automatic vsmul_saturation();
    int    e0;
    int    w;
    vreg_t a;
    vreg_t b;
    e0 = err_count;
    for (int e = 0; e < 3; e++) begin
      w = 8 << e;
      a = rand_vreg();
      b = rand_vreg();
      for (int i = 0; i < vlen / w; i += 2) begin   // even elements min * min
        a = set_elem(a, w, i, 32'd1 << (w - 1));
        b = set_elem(b, w, i, 32'd1 << (w - 1));
      end
      run_uop(op_vsmul, vxrm_rnu, 3'(e), 1'b0, a, b, 32'd0, 3'b110, "vsmul saturation");
    end
    report_test("vsmul saturation", e0);
  endtask

  task automatic back_to_back();
    int                       e0;
    vreg_t                    exp_d [8];
    vmask_t                   exp_s [8];
    logic [rob_idx_width-1:0] ents [8];
    vreg_t                    a;
    vreg_t                    b;
    logic [xlen-1:0]          rs;
    e0 = err_count;
    @(negedge clk);
    if (rslt_valid !== 1'b0) begin
      $display("rslt_valid was not low on an idle cycle");
      err_count++;
    end
    for (int k = 0; k <= 8; k++) begin
      @(negedge clk);
      if (k > 0) begin
        if (!rslt_valid) begin
          $display("back to back uop %0d gave no result one cycle later", k - 1);
          err_count++;
        end
        check_entry(rslt_rob_entry, ents[k-1], "back to back");
        check_data(rslt_data, exp_d[k-1], "back to back");
        check_vxsat(rslt_vxsat, exp_s[k-1], "back to back");
      end
      if (k < 8) begin
        a       = rand_vreg();
        b       = rand_vreg();
        rs      = rand_bits(32);
        ents[k] = rob_idx_width'(k * 5 + 3);
        form_expect(k % 5, 2'(k % 4), 3'(k % 3), (k % 2) == 1, a, b, rs, 3'b111,
                    exp_d[k], exp_s[k]);
        drive_uop(k % 5, 2'(k % 4), 3'(k % 3), (k % 2) == 1, a, b, rs, 3'b111, ents[k]);
      end else begin
        uop_valid = 1'b0;
      end
    end
    @(negedge clk);
    if (rslt_valid !== 1'b0) begin
      $display("rslt_valid stayed high after the last uop");
      err_count++;
    end
    report_test("back to back", e0);
  endtask

  //////////////////////////////
  // watchdog
  initial begin
    repeat (n_tests * cycles_per_test + margin) @(posedge clk);
    $display("simulation timed out before the tests finished");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    reset         = 1'b1;
    uop_valid     = 1'b1;   // only the reset may keep stage 1 empty
    uop_funct3    = '0;
    uop_funct6    = '0;
    uop_vxrm      = '0;
    uop_eew       = '0;
    uop_rob_entry = '0;
    vs1_data      = '0;
    vs1_valid     = 1'b0;
    vs2_data      = '0;
    vs2_valid     = 1'b0;
    rs1_data      = '0;
    rs1_valid     = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset     = 1'b0;
    uop_valid = 1'b0;
    if (rslt_valid !== 1'b0) begin
      $display("rslt_valid was not low right after reset");
      err_count++;
    end
    vmul_low_half();
    high_half_forms();
    scalar_and_invalid();
    vsmul_rounding();
    vsmul_saturation();
    back_to_back();
    $display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/vmul_byte_array.sv */
//////////////////////////////
// byte multiplier array
// 8x8 products in 4x4 tiles, registered into stage 1
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vmul_byte_array
  import vmul_cfg_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  vreg_t                  opa,
  input  vreg_t                  opb,
  input  vmask_t                 opa_signed,
  input  vmask_t                 opb_signed,
  output logic [nprod-1:0][15:0] prod
);

  logic [nprod-1:0][15:0] prod_d;

  // one 8x8 multiply, each input extended by its lane flag
  function automatic logic [15:0] mul8(
    input logic [7:0] a,
    input logic       a_sgn,
    input logic [7:0] b,
    input logic       b_sgn
  );
    logic signed [8:0]  a_ext;
    logic signed [8:0]  b_ext;
    logic signed [17:0] p;
    a_ext = {a_sgn & a[7], a};
    b_ext = {b_sgn & b[7], b};
    p     = a_ext * b_ext;
    return p[15:0];   // fits for every sign mix
  endfunction

  // tile z pairs a lanes z*4+x with b lanes z*4+y
  always_comb begin
    for (int z = 0; z < tiles; z++) begin
      for (int y = 0; y < 4; y++) begin
        for (int x = 0; x < 4; x++) begin
          prod_d[z*16+y*4+x] = mul8(opa.b[z*4+x], opa_signed[z*4+x],
                                    opb.b[z*4+y], opb_signed[z*4+y]);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      prod <= '0;
    end else begin
      prod <= prod_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/vmul_cfg_pkg.sv */
//////////////////////////////
// vector multiply geometry
// widths, element codes and the shared vector register view
//////////////////////////////

`default_nettype none

package vmul_cfg_pkg;

  localparam int vlen          = 128;          // vector register width
  localparam int vlenb         = vlen / 8;     // byte lanes
  localparam int xlen          = 32;           // scalar register width
  localparam int rob_idx_width = 4;
  localparam int tiles         = vlenb / 4;    // 32-bit groups in the byte array
  localparam int nprod         = 4 * vlenb;    // 8x8 products, 16 per tile

  // element width codes
  localparam logic [2:0] eew8  = 3'd0;
  localparam logic [2:0] eew16 = 3'd1;
  localparam logic [2:0] eew32 = 3'd2;

  // one vector register, read per element width
  typedef union packed {
    logic [vlenb-1:0][7:0]    b;   // bytes
    logic [vlenb/2-1:0][15:0] h;   // halfwords
    logic [vlenb/4-1:0][31:0] w;   // words
  } vreg_t;

  typedef logic [vlenb-1:0] vmask_t;   // one bit per byte lane

endpackage

`default_nettype wire

/* hdl/vmul_combine.sv */
//////////////////////////////
// partial product combine
// builds 16, 32 and 64-bit element products from byte products
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vmul_combine
  import vmul_cfg_pkg::*;
(
  input  logic [nprod-1:0][15:0]   prod,
  input  logic                     s1_src1_signed,
  input  logic                     s1_src2_signed,
  output logic [vlenb-1:0][15:0]   full8,
  output logic [vlenb/2-1:0][31:0] full16,
  output logic [tiles-1:0][63:0]   full32
);

  function automatic logic [63:0] ext_prod(input logic [15:0] p, input logic sgn);
    return {{48{sgn & p[15]}}, p};
  endfunction

  // shifted sum of the n x n byte products of one element
  function automatic logic [63:0] sum_elem(
    input logic [nprod-1:0][15:0] pp,
    input int                     base,
    input int                     n,
    input logic                   b_sgn,
    input logic                   a_sgn
  );
    logic [63:0] acc;
    logic        sext;
    acc = '0;
    for (int y = 0; y < n; y++) begin
      for (int x = 0; x < n; x++) begin
        // only products touching a top lane can be negative
        sext = (x == n-1 && a_sgn) || (y == n-1 && b_sgn);
        acc  = acc + (ext_prod(pp[base+y*4+x], sext) << (8*(x+y)));
      end
    end
    return acc;
  endfunction

  // eew8 products sit on the tile diagonal
  always_comb begin
    for (int z = 0; z < tiles; z++) begin
      for (int j = 0; j < 4; j++) begin
        full8[z*4+j] = prod[z*16+j*5];
      end
    end
  end

  always_comb begin
    for (int k = 0; k < vlenb/2; k++) begin
      full16[k] = 32'(sum_elem(prod, (k/2)*16 + (k%2)*10, 2,
                               s1_src1_signed, s1_src2_signed));
    end
  end

  always_comb begin
    for (int z = 0; z < tiles; z++) begin
      full32[z] = sum_elem(prod, z*16, 4, s1_src1_signed, s1_src2_signed);
    end
  end

endmodule

`default_nettype wire

/* hdl/vmul_issue.sv */
//////////////////////////////
// multiply issue stage
// decodes the uop, builds the byte operands and registers
// the controls for stage 1
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vmul_issue
  import vmul_cfg_pkg::*, vmul_op_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     uop_valid,
  input  logic [2:0]               uop_funct3,
  input  logic [5:0]               uop_funct6,
  input  logic [1:0]               uop_vxrm,
  input  logic [2:0]               uop_eew,
  input  logic [rob_idx_width-1:0] uop_rob_entry,
  input  vreg_t                    vs1_data,
  input  logic                     vs1_valid,
  input  vreg_t                    vs2_data,
  input  logic                     vs2_valid,
  input  logic [xlen-1:0]          rs1_data,
  input  logic                     rs1_valid,
  output vreg_t                    opa,
  output vreg_t                    opb,
  output vmask_t                   opa_signed,
  output vmask_t                   opb_signed,
  output logic                     s1_valid,
  output logic [rob_idx_width-1:0] s1_rob_entry,
  output logic [2:0]               s1_eew,
  output logic [1:0]               s1_vxrm,
  output logic                     s1_src1_signed,
  output logic                     s1_src2_signed,
  output logic                     s1_keep_low,
  output logic                     s1_is_vsmul
);

  logic                 op_ok;       // funct3 is a multiply class
  logic                 is_vx;       // b comes from rs1
  logic [ctl_width-1:0] ctl;
  vreg_t                vec_b;
  logic [xlen-1:0]      scl_b;
  logic                 width_ok;
  logic [1:0]           lane_mask;   // byte index within an element

  //////////////////////////////
  // opcode decode
  always_comb begin
    op_ok = 1'b0;
    is_vx = 1'b0;
    ctl   = '0;
    if (uop_valid) begin
      case (uop_funct3)
        opmvv, opmvx: begin
          op_ok = 1'b1;
          is_vx = (uop_funct3 == opmvx);
          case (uop_funct6)
            f6_vmulh: begin
              ctl[ctl_src1_signed] = 1'b1;
              ctl[ctl_src2_signed] = 1'b1;
            end
            f6_vmulhu:  ctl = '0;                      // both unsigned
            f6_vmulhsu: ctl[ctl_src2_signed] = 1'b1;   // a signed only
            default: begin                             // vmul and unknown codes
              ctl[ctl_src1_signed] = 1'b1;
              ctl[ctl_src2_signed] = 1'b1;
              ctl[ctl_keep_low]    = 1'b1;
            end
          endcase
        end
        opivv, opivx: begin                            // vsmul whatever funct6
          op_ok = 1'b1;
          is_vx = (uop_funct3 == opivx);
          ctl[ctl_src1_signed] = 1'b1;
          ctl[ctl_src2_signed] = 1'b1;
          ctl[ctl_is_vsmul]    = 1'b1;
        end
        default: op_ok = 1'b0;
      endcase
    end
  end

  // a source with no valid data reads as zero
  assign opa   = (op_ok && vs2_valid) ? vs2_data : '0;
  assign vec_b = (op_ok && vs1_valid) ? vs1_data : '0;
  assign scl_b = (op_ok && rs1_valid) ? rs1_data : '0;

  always_comb begin
    width_ok  = 1'b1;
    lane_mask = 2'd0;
    case (uop_eew)
      eew8:    lane_mask = 2'd0;
      eew16:   lane_mask = 2'd1;
      eew32:   lane_mask = 2'd3;
      default: width_ok  = 1'b0;   // reserved, result reads zero
    endcase
  end

  // scalar splat and per-lane sign flags
  always_comb begin
    opb        = vec_b;
    opa_signed = '0;
    opb_signed = '0;
    for (int i = 0; i < vlenb; i++) begin
      if (width_ok) begin
        if (is_vx) begin
          opb.b[i] = scl_b[8*(2'(i) & lane_mask) +: 8];
        end
        if ((2'(i) & lane_mask) == lane_mask) begin   // top byte of the element
          opa_signed[i] = ctl[ctl_src2_signed];
          opb_signed[i] = ctl[ctl_src1_signed];
        end
      end
    end
  end

  //////////////////////////////
  // stage 1 control registers
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid       <= 1'b0;
      s1_rob_entry   <= '0;
      s1_eew         <= '0;
      s1_vxrm        <= '0;
      s1_src1_signed <= 1'b0;
      s1_src2_signed <= 1'b0;
      s1_keep_low    <= 1'b0;
      s1_is_vsmul    <= 1'b0;
    end else begin
      s1_valid       <= uop_valid;
      s1_rob_entry   <= uop_rob_entry;
      s1_eew         <= uop_eew;
      s1_vxrm        <= uop_vxrm;
      s1_src1_signed <= ctl[ctl_src1_signed];
      s1_src2_signed <= ctl[ctl_src2_signed];
      s1_keep_low    <= ctl[ctl_keep_low];
      s1_is_vsmul    <= ctl[ctl_is_vsmul];
    end
  end

endmodule

`default_nettype wire

/* hdl/vmul_op_pkg.sv */
//////////////////////////////
// vector multiply opcodes
// funct3/funct6 values, vxrm codes and uop control bits
//////////////////////////////

`default_nettype none

package vmul_op_pkg;

  // funct3 classes
  localparam logic [2:0] opivv = 3'b000;
  localparam logic [2:0] opivx = 3'b100;
  localparam logic [2:0] opmvv = 3'b010;
  localparam logic [2:0] opmvx = 3'b110;

  // funct6 codes, opm class except vsmul
  localparam logic [5:0] f6_vmul    = 6'b100101;
  localparam logic [5:0] f6_vmulh   = 6'b100111;
  localparam logic [5:0] f6_vmulhu  = 6'b100100;
  localparam logic [5:0] f6_vmulhsu = 6'b100110;
  localparam logic [5:0] f6_vsmul   = 6'b100111;   // opi class

  // fixed-point rounding modes
  localparam logic [1:0] vxrm_rnu = 2'd0;   // round to nearest up
  localparam logic [1:0] vxrm_rne = 2'd1;   // round to nearest even
  localparam logic [1:0] vxrm_rdn = 2'd2;   // truncate
  localparam logic [1:0] vxrm_rod = 2'd3;   // round to odd

  // bit positions in the decoded control word
  localparam int ctl_src1_signed = 0;   // operand b (vs1/rs1)
  localparam int ctl_src2_signed = 1;   // operand a (vs2)
  localparam int ctl_keep_low    = 2;
  localparam int ctl_is_vsmul    = 3;
  localparam int ctl_width       = 4;

endpackage

`default_nettype wire

/* hdl/vmul_round_sat.sv */
//////////////////////////////
// result select, rounding and saturation
// picks low/high half or the vsmul value per width
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vmul_round_sat
  import vmul_cfg_pkg::*, vmul_op_pkg::*;
(
  input  logic [vlenb-1:0][15:0]   full8,
  input  logic [vlenb/2-1:0][31:0] full16,
  input  logic [tiles-1:0][63:0]   full32,
  input  logic [2:0]               s1_eew,
  input  logic [1:0]               s1_vxrm,
  input  logic                     s1_keep_low,
  input  logic                     s1_is_vsmul,
  output vreg_t                    rslt_data,
  output vmask_t                   rslt_vxsat
);

  vreg_t  res8;
  vreg_t  res16;
  vreg_t  res32;
  vmask_t sat8;
  vmask_t sat16;
  vmask_t sat32;

  // one element of width w from its 2w-bit product, {sat, value}
  function automatic logic [32:0] elem_rslt(
    input logic [63:0] p,
    input int          w,
    input logic [1:0]  vxrm,
    input logic        keep_low,
    input logic        is_vsmul
  );
    logic [63:0] mask;
    logic [63:0] kept;
    logic        lsb;
    logic        top;
    logic        rest;
    logic        incr;
    logic        sat;
    mask = (64'd1 << w) - 64'd1;
    kept = (p >> (w-1)) & mask;          // product >> (w-1)
    lsb  = p[w-1];
    top  = p[w-2];                       // first discarded bit
    rest = |(p & (mask >> 2));           // remaining discarded bits
    // only min * min reaches 2^(2w-2)
    sat  = is_vsmul && (((p >> (2*w-2)) & 64'd3) == 64'd1);
    incr = 1'b0;
    case (vxrm)
      vxrm_rnu: incr = top;
      vxrm_rne: incr = top & (rest | lsb);
      vxrm_rdn: incr = 1'b0;
      vxrm_rod: incr = ~lsb & (top | rest);
    endcase
    if (sat) begin
      return {1'b1, 32'(mask >> 1)};     // largest positive
    end
    if (is_vsmul) begin
      return {1'b0, 32'(kept + 64'(incr))};
    end
    if (keep_low) begin
      return {1'b0, 32'(p & mask)};
    end
    return {1'b0, 32'((p >> w) & mask)};
  endfunction

  always_comb begin
    logic [32:0] r;
    res8  = '0;
    res16 = '0;
    res32 = '0;
    sat8  = '0;
    sat16 = '0;
    sat32 = '0;
    for (int i = 0; i < vlenb; i++) begin
      r          = elem_rslt({48'b0, full8[i]}, 8, s1_vxrm, s1_keep_low, s1_is_vsmul);
      res8.b[i]  = r[7:0];
      sat8[i]    = r[32];
    end
    for (int i = 0; i < vlenb/2; i++) begin
      r          = elem_rslt({32'b0, full16[i]}, 16, s1_vxrm, s1_keep_low, s1_is_vsmul);
      res16.h[i] = r[15:0];
      sat16[2*i+1] = r[32];              // msb lane of the halfword
    end
    for (int i = 0; i < tiles; i++) begin
      r          = elem_rslt(full32[i], 32, s1_vxrm, s1_keep_low, s1_is_vsmul);
      res32.w[i] = r[31:0];
      sat32[4*i+3] = r[32];              // msb lane of the word
    end
  end

  //////////////////////////////
  // width select
  always_comb begin
    case (s1_eew)
      eew8: begin
        rslt_data  = res8;
        rslt_vxsat = sat8;
      end
      eew16: begin
        rslt_data  = res16;
        rslt_vxsat = sat16;
      end
      eew32: begin
        rslt_data  = res32;
        rslt_vxsat = sat32;
      end
      default: begin
        rslt_data  = '0;
        rslt_vxsat = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/vmul_unit.sv */
//////////////////////////////
// vector integer multiply unit
// one uop per cycle, result one clock later
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module vmul_unit
  import vmul_cfg_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     uop_valid,
  input  logic [2:0]               uop_funct3,
  input  logic [5:0]               uop_funct6,
  input  logic [1:0]               uop_vxrm,
  input  logic [2:0]               uop_eew,
  input  logic [rob_idx_width-1:0] uop_rob_entry,
  input  vreg_t                    vs1_data,
  input  logic                     vs1_valid,
  input  vreg_t                    vs2_data,
  input  logic                     vs2_valid,
  input  logic [xlen-1:0]          rs1_data,
  input  logic                     rs1_valid,
  output logic                     rslt_valid,
  output logic [rob_idx_width-1:0] rslt_rob_entry,
  output vreg_t                    rslt_data,
  output vmask_t                   rslt_vxsat
);

  vreg_t                    opa;
  vreg_t                    opb;
  vmask_t                   opa_signed;
  vmask_t                   opb_signed;
  logic [2:0]               s1_eew;
  logic [1:0]               s1_vxrm;
  logic                     s1_src1_signed;
  logic                     s1_src2_signed;
  logic                     s1_keep_low;
  logic                     s1_is_vsmul;
  logic [nprod-1:0][15:0]   prod;      // stage 1 byte products
  logic [vlenb-1:0][15:0]   full8;
  logic [vlenb/2-1:0][31:0] full16;
  logic [tiles-1:0][63:0]   full32;

  vmul_issue u_issue (
    .clk            (clk),
    .reset          (reset),
    .uop_valid      (uop_valid),
    .uop_funct3     (uop_funct3),
    .uop_funct6     (uop_funct6),
    .uop_vxrm       (uop_vxrm),
    .uop_eew        (uop_eew),
    .uop_rob_entry  (uop_rob_entry),
    .vs1_data       (vs1_data),
    .vs1_valid      (vs1_valid),
    .vs2_data       (vs2_data),
    .vs2_valid      (vs2_valid),
    .rs1_data       (rs1_data),
    .rs1_valid      (rs1_valid),
    .opa            (opa),
    .opb            (opb),
    .opa_signed     (opa_signed),
    .opb_signed     (opb_signed),
    .s1_valid       (rslt_valid),       // valid and tag leave as they are
    .s1_rob_entry   (rslt_rob_entry),
    .s1_eew         (s1_eew),
    .s1_vxrm        (s1_vxrm),
    .s1_src1_signed (s1_src1_signed),
    .s1_src2_signed (s1_src2_signed),
    .s1_keep_low    (s1_keep_low),
    .s1_is_vsmul    (s1_is_vsmul)
  );

  vmul_byte_array u_array (
    .clk        (clk),
    .reset      (reset),
    .opa        (opa),
    .opb        (opb),
    .opa_signed (opa_signed),
    .opb_signed (opb_signed),
    .prod       (prod)
  );

  vmul_combine u_combine (
    .prod           (prod),
    .s1_src1_signed (s1_src1_signed),
    .s1_src2_signed (s1_src2_signed),
    .full8          (full8),
    .full16         (full16),
    .full32         (full32)
  );

  vmul_round_sat u_round_sat (
    .full8       (full8),
    .full16      (full16),
    .full32      (full32),
    .s1_eew      (s1_eew),
    .s1_vxrm     (s1_vxrm),
    .s1_keep_low (s1_keep_low),
    .s1_is_vsmul (s1_is_vsmul),
    .rslt_data   (rslt_data),
    .rslt_vxsat  (rslt_vxsat)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the multiply unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_vmul_unit -f vlog.f -o vsim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/vsim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
  exit 0
fi
echo "simulation did not pass"
exit 1

/* vlog.f */
+incdir+bench
hdl/vmul_cfg_pkg.sv
hdl/vmul_op_pkg.sv
hdl/vmul_issue.sv
hdl/vmul_byte_array.sv
hdl/vmul_combine.sv
hdl/vmul_round_sat.sv
hdl/vmul_unit.sv
bench/tb_vmul_unit.sv
